// File: verilog.f
verilog/cache_pkg.sv
verilog/cache_lookup.sv
verilog/cache_fill_ctrl.sv
verilog/cache_data_array.sv
verilog/icache_top.sv
test/icache_assert.sv
test/icache_checker.sv
test/icache_tb.sv

// File: Makefile
TOP := icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
	  echo "Simulation failed, see sim.log."; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: test/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

  localparam int MEM_LATENCY  = 4;
  localparam int RESET_CYCLES = 8;
  localparam int N_TESTS      = 12;
  // A miss with the longest grant delay is the longest test.
  localparam int MAX_CYCLES   = N_TESTS * (12 + MEM_LATENCY + 8) + RESET_CYCLES;

  typedef struct packed {
    logic [15:0] addr; // Byte address of the request.
    logic        hit;  // Outcome expected from the cache.
  } vec_t;

  // Lines 0x12, 0x33 and 0x3f get filled. 0x0524 evicts 0x0124 from line 0x12.
  localparam vec_t VECS [N_TESTS] = '{
    {16'h0124, 1'b0}, {16'h012a, 1'b1}, {16'h0120, 1'b1}, {16'h0b36, 1'b0},
    {16'h0b3e, 1'b1}, {16'h0524, 1'b0}, {16'h052c, 1'b1}, {16'h0128, 1'b0},
    {16'h0b30, 1'b1}, {16'hfffe, 1'b0}, {16'h0126, 1'b1}, {16'hfff0, 1'b1}
  };

  logic                clk;
  logic                arst_n;
  cache_pkg::cpu_req_t req;
  cache_pkg::cpu_rsp_t rsp;
  logic                busy;
  logic                grant;
  logic                mem_en;
  logic [15:0]         mem_addr;
  logic                mem_valid;
  logic [15:0]         mem_data;
  logic                tbl_hit;
  logic [16:0]         mem_pipe [MEM_LATENCY] = '{default: '0}; // Reads in flight.
  int                  grant_dly [N_TESTS];
  int                  seed   = 32'he8b8;
  int                  cycles = 0;
  int                  n_tests;
  int                  n_errors;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model, each read returns exactly MEM_LATENCY cycles later.
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    mem_pipe[0] <= {mem_en, mem_en ? mem_addr : 16'h0000}; // Valid bit on top.
    for (int i = 1; i < MEM_LATENCY; i++) begin
      mem_pipe[i] <= mem_pipe[i-1];
    end
  end

  assign mem_valid = mem_pipe[MEM_LATENCY-1][16];
  assign mem_data  = mem_pipe[MEM_LATENCY-1][15:0] ^ 16'ha5c3;

  icache_top #(.MEM_LATENCY(MEM_LATENCY)) dut_i (
    .clk, .arst_n, .req, .rsp, .busy, .grant, .mem_en, .mem_addr, .mem_valid, .mem_data
  );

  icache_checker chk_i (
    .clk, .arst_n, .req, .tbl_hit, .rsp, .busy, .grant, .mem_en, .mem_addr, .n_tests, .n_errors
  );

  // One request, then grant the memory some cycles after busy rises.
  task automatic run_request(input vec_t v, input int dly);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clk);
    req     <= {1'b1, v.addr};
    tbl_hit <= v.hit;
    @(posedge clk);
    req.strobe <= 1'b0; // Strobe lasts a single cycle.
    while (!rsp.strobe) begin
      if (busy) begin
        if (wait_cnt >= dly) grant <= 1'b1; // Held until the line is filled.
        wait_cnt++;
      end
      @(posedge clk);
    end
    grant <= 1'b0;
  endtask

  initial begin
    arst_n  = 1'b0;
    req     = '0;
    grant   = 1'b0;
    tbl_hit = 1'b0;
    for (int i = 0; i < N_TESTS; i++) begin
      grant_dly[i] = $unsigned($random(seed)) % 8;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      run_request(VECS[i], grant_dly[i]);
    end
    repeat (2) @(posedge clk);
    $display("Tests answered %0d of %0d, check errors %0d, assertion failures %0d.", n_tests,
             N_TESTS, n_errors, dut_i.fill_ctrl_i.assert_i.fail_cnt);
    if (n_errors == 0 && n_tests == N_TESTS && dut_i.fill_ctrl_i.assert_i.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the cache stopped answering requests.", MAX_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: test/icache_checker.sv
`timescale 1ns/100ps

module icache_checker (
  input  logic                clk,      // Testbench clock.
  input  logic                arst_n,   // DUT reset.
  input  cache_pkg::cpu_req_t req,      // Request as the DUT sees it.
  input  logic                tbl_hit,  // Outcome the stimulus table lists.
  input  cache_pkg::cpu_rsp_t rsp,      // Response of the DUT.
  input  logic                busy,
  input  logic                grant,
  input  logic                mem_en,
  input  logic [15:0]         mem_addr,
  output int                  n_tests,  // Requests answered so far.
  output int                  n_errors  // Failed checks so far.
);

  logic [5:0]             shadow_tag [64];   // Tag each line should hold.
  logic [63:0]            shadow_valid = '0;
  cache_pkg::cache_addr_t addr;              // Request that is open.
  logic                   pending = 1'b0;
  logic                   exp_hit = 1'b0;
  logic [15:0]            exp_word;
  int                     cyc      = 0;
  int                     req_cyc  = 0;
  int                     en_cnt   = 0;      // Memory reads seen for the open request.
  int                     test_err = 0;
  int                     tests_q  = 0;
  int                     errors_q = 0;

  assign n_tests  = tests_q;
  assign n_errors = errors_q;

  task automatic report_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors_q++;
    test_err++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampled at the falling edge, halfway between two drive edges.
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    cyc++;
    if (!arst_n) begin
      shadow_valid = '0; // The cache starts with every line invalid.
      pending      = 1'b0;
      if (rsp.strobe || busy || mem_en) report_error("Outputs are active during reset.");
    end else if (req.strobe) begin
      if (pending || busy) report_error("A request was issued while busy.");
      addr     = req.addr;
      exp_hit  = shadow_valid[addr.fields.index] &&
                 shadow_tag[addr.fields.index] == addr.fields.tag;
      pending  = 1'b1;
      req_cyc  = cyc;
      en_cnt   = 0;
      test_err = 0;
      if (exp_hit != tbl_hit) report_error("Stimulus table and shadow tags disagree.");
    end else if (pending) begin
      if (mem_en) begin
        exp_word = {addr.raw[15:4], 4'h0} + 16'(2 * en_cnt); // Block base, then even steps.
        if (exp_hit || !grant || mem_addr != exp_word) begin
          report_error($sformatf("mem_addr %h with grant %0b on hit %0b, expected %h.",
                                 mem_addr, grant, exp_hit, exp_word));
        end
        en_cnt++;
      end
      if (rsp.strobe) begin
        exp_word = {addr.raw[15:1], 1'b0} ^ 16'ha5c3; // Pattern of the memory model.
        if (rsp.hit != exp_hit || rsp.data != exp_word) begin
          report_error($sformatf("Response hit %0b data %h, expected hit %0b data %h.",
                                 rsp.hit, rsp.data, exp_hit, exp_word));
        end
        if (busy || (exp_hit && cyc != req_cyc + 1) || (!exp_hit && en_cnt != 8)) begin
          report_error($sformatf("Response after %0d cycles, busy %0b, %0d memory reads.",
                                 cyc - req_cyc, busy, en_cnt));
        end
        if (!exp_hit) begin
          shadow_valid[addr.fields.index] = 1'b1; // The fill replaces the whole line.
          shadow_tag[addr.fields.index]   = addr.fields.tag;
        end
        tests_q++;
        $display("Test %0d at %0t: addr %h, %s in %0d cycles, %0d errors.", tests_q, $time,
                 addr.raw, exp_hit ? "hit" : "miss", cyc - req_cyc, test_err);
        pending = 1'b0;
      end else if (!busy || (exp_hit && cyc == req_cyc + 1)) begin
        report_error("busy is low or the hit response is missing while a request is open.");
      end
    end else if (rsp.strobe || busy || mem_en) begin
      report_error("rsp, busy or mem_en is active with no request open.");
    end
  end

endmodule

// File: test/icache_assert.sv
`timescale 1ns/100ps

module icache_assert (
  input logic       clk,       // System clock.
  input logic       arst_n,    // Asynchronous reset, active low.
  input logic [1:0] state,     // State of the fill FSM.
  input logic       mem_en,    // Memory read enable.
  input logic       wr_strobe, // Word write into the data array.
  input logic       tag_wr     // Tag write into the lookup.
);

  localparam logic [1:0] IDLE = 2'd0; // Encoding of IDLE in the fill FSM.

  int         fail_cnt = 0; // Failed assertions, read by the testbench top.
  logic [3:0] wr_seen;      // Word writes seen since the last tag write.

  // Counted from the write strobes alone, apart from the FSM's own counter.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_seen <= '0;
    end else if (tag_wr) begin
      wr_seen <= '0; // A new line starts after the tag goes in.
    end else if (wr_strobe) begin
      wr_seen <= wr_seen + 1'b1;
    end
  end

  // The address stream only runs while a miss is served.
  idle_quiet: assert property (@(posedge clk) disable iff (!arst_n) state == IDLE |-> !mem_en)
    else begin
      $error("mem_en is high while the fill FSM is idle.");
      fail_cnt++;
    end

  // One burst covers the eight words of a line.
  burst_len: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(mem_en) |-> mem_en [*8] ##1 !mem_en)
    else begin
      $error("mem_en did not stay high for exactly eight cycles.");
      fail_cnt++;
    end

  // The eighth write of a fill carries the tag, and no other write does.
  tag_last: assert property (@(posedge clk) disable iff (!arst_n)
    tag_wr == (wr_strobe && wr_seen == 4'd7))
    else begin
      $error("The tag write does not line up with the eighth word.");
      fail_cnt++;
    end

endmodule

bind cache_fill_ctrl icache_assert assert_i (
  .clk, .arst_n, .state, .mem_en, .wr_strobe(wr.strobe), .tag_wr
);

// File: verilog/icache_top.sv
`timescale 1ns/100ps

module icache_top #(
  parameter int MEM_LATENCY = 4 // Passed down to the fill controller.
) (
  input  logic                clk,       // System clock.
  input  logic                arst_n,    // Asynchronous reset, active low.
  input  cache_pkg::cpu_req_t req,       // Processor request.
  output cache_pkg::cpu_rsp_t rsp,       // Cache response.
  output logic                busy,      // Miss in progress.
  input  logic                grant,     // Memory grant for a line fill.
  output logic                mem_en,    // Memory read enable.
  output logic [15:0]         mem_addr,  // Memory read address.
  input  logic                mem_valid, // Memory data is valid.
  input  logic [15:0]         mem_data   // Memory read data.
);

  cache_pkg::fill_cmd_t  cmd;          // Lookup to fill control.
  cache_pkg::fill_wr_t   wr;           // Fill control to data array.
  cache_pkg::tag_entry_t tag_wr_entry;
  logic                  tag_wr;
  logic                  fill_busy;
  logic [5:0]            rd_index;
  logic [2:0]            rd_offset;
  logic                  rsp_valid;
  logic                  rsp_hit;
  logic [15:0]           rd_data;

  // Input side.
  cache_lookup lookup_i (
    .clk, .arst_n, .req, .tag_wr, .tag_wr_entry, .fill_busy,
    .cmd, .rd_index, .rd_offset, .rsp_valid, .rsp_hit, .busy
  );

  cache_fill_ctrl #(.MEM_LATENCY(MEM_LATENCY)) fill_ctrl_i (
    .clk, .arst_n, .cmd, .grant, .mem_valid, .mem_data,
    .mem_en, .mem_addr, .wr, .tag_wr, .tag_wr_entry, .fill_busy
  );

  // Output side.
  cache_data_array data_array_i (
    .clk, .wr, .rd_index, .rd_offset, .rd_data
  );

  assign rsp.strobe = rsp_valid;
  assign rsp.hit    = rsp_hit;
  assign rsp.data   = rd_data; // Lines up with the strobe through the registered read.

endmodule

// File: verilog/cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array (
  input  logic                clk,       // System clock.
  input  cache_pkg::fill_wr_t wr,        // Word write from the fill controller.
  input  logic [5:0]          rd_index,  // Line to read.
  input  logic [2:0]          rd_offset, // Word inside the line.
  output logic [15:0]         rd_data    // Word read in the previous cycle.
);

  localparam int DEPTH = 64 * cache_pkg::LINE_WORDS; // 512 words in all.

  logic [15:0] mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Fill writes.
  //////////////////////////////////////////////////////////////////////
  // The word address is index and offset side by side, so one line is
  // eight neighbouring entries.
  always_ff @(posedge clk) begin
    if (wr.strobe) begin
      mem[{wr.addr.fields.index, wr.addr.fields.offset}] <= wr.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registered read.
  //////////////////////////////////////////////////////////////////////
  // The read takes one cycle, the same as the tag compare in the lookup.
  // The word therefore appears together with the response strobe.
  always_ff @(posedge clk) begin
    rd_data <= mem[{rd_index, rd_offset}];
  end

endmodule

// File: verilog/cache_fill_ctrl.sv
`timescale 1ns/100ps

module cache_fill_ctrl #(
  parameter int MEM_LATENCY = 4 // Cycles from a memory address to its data.
) (
  input  logic                  clk,          // System clock.
  input  logic                  arst_n,       // Asynchronous reset, active low.
  input  cache_pkg::fill_cmd_t  cmd,          // Miss command from the lookup.
  input  logic                  grant,        // Memory may be used for the fill.
  input  logic                  mem_valid,    // Memory returns a word this cycle.
  input  logic [15:0]           mem_data,     // Word returned by memory.
  output logic                  mem_en,       // Memory read enable.
  output logic [15:0]           mem_addr,     // Memory read address.
  output cache_pkg::fill_wr_t   wr,           // Word write to the data array.
  output logic                  tag_wr,       // Tag write to the lookup.
  output cache_pkg::tag_entry_t tag_wr_entry, // Entry that goes with tag_wr.
  output logic                  fill_busy     // A line fill is in progress.
);

  typedef enum logic [1:0] {
    IDLE = 2'd0, // Waiting for a miss.
    WAIT = 2'd1, // Miss taken, waiting for the memory grant.
    SEND = 2'd2  // Streaming addresses and collecting the returned words.
  } state_t;

  localparam int CNT_W = $clog2(cache_pkg::LINE_WORDS);

  state_t                 state;
  state_t                 nxt_state;
  cache_pkg::cache_addr_t addr_q;                 // Address sent to memory.
  cache_pkg::cache_addr_t addr_dly [MEM_LATENCY]; // Addresses in flight.
  logic [CNT_W-1:0]       word_cnt;               // Words returned so far.
  logic                   load;       // Capture a new miss.
  logic                   set_mem_en; // Start the address stream.
  logic                   clr_mem_en; // Last address goes out this cycle.
  logic                   last_addr;
  logic                   last_word;
  logic                   fill_wr;

  //////////////////////////////////////////////////////////////////////
  // Memory address counter and delay chain.
  //////////////////////////////////////////////////////////////////////
  assign last_addr = addr_q.fields.offset == 3'(cache_pkg::LINE_WORDS - 1);

  always_ff @(posedge clk) begin
    if (load) begin
      addr_q <= cmd.addr; // Block base.
    end else if (mem_en && !last_addr) begin
      addr_q.raw <= addr_q.raw + 16'd2; // Next word, stops at the end of the line.
    end
  end

  assign mem_addr = addr_q.raw;

  // Each address is delayed by the memory latency, so the tail of the chain
  // names the word that memory is returning right now.
  always_ff @(posedge clk) begin
    addr_dly[0] <= addr_q;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      addr_dly[i] <= addr_dly[i-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word counter.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_cnt <= '0;
    end else if (load) begin
      word_cnt <= '0;
    end else if (fill_wr) begin
      word_cnt <= word_cnt + 1'b1; // Wraps back to zero with the eighth word.
    end
  end

  assign last_word = mem_valid & (word_cnt == CNT_W'(cache_pkg::LINE_WORDS - 1));

  //////////////////////////////////////////////////////////////////////
  // State register and set/clear flops.
  //////////////////////////////////////////////////////////////////////
  assign clr_mem_en = mem_en & last_addr; // Eight addresses have then been sent.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      mem_en    <= 1'b0;
      fill_busy <= 1'b0;
    end else begin
      state <= nxt_state;
      if (set_mem_en) begin
        mem_en <= 1'b1;
      end else if (clr_mem_en) begin
        mem_en <= 1'b0;
      end
      if (load) begin
        fill_busy <= 1'b1;
      end else if (tag_wr) begin
        fill_busy <= 1'b0; // Line complete, the lookup may replay.
      end
    end
  end

  // Next state and strobes.
  always_comb begin
    nxt_state  = state;
    load       = 1'b0;
    set_mem_en = 1'b0;
    fill_wr    = 1'b0;
    tag_wr     = 1'b0;
    case (state)
      IDLE: begin
        load = cmd.miss;
        if (cmd.miss) nxt_state = WAIT;
      end
      WAIT: begin
        set_mem_en = grant; // mem_en stays low until memory is granted.
        if (grant) nxt_state = SEND;
      end
      SEND: begin
        fill_wr = mem_valid;
        tag_wr  = last_word; // Tag goes in with the eighth word.
        if (last_word) nxt_state = IDLE;
      end
      default: nxt_state = IDLE;
    endcase
  end

  assign wr.strobe = fill_wr;
  assign wr.addr   = addr_dly[MEM_LATENCY-1];
  assign wr.data   = mem_data;

  // Every word of the line carries the same tag.
  assign tag_wr_entry.tag   = addr_dly[MEM_LATENCY-1].fields.tag;
  assign tag_wr_entry.valid = 1'b1;

endmodule

// File: verilog/cache_lookup.sv
`timescale 1ns/100ps

module cache_lookup (
  input  logic                  clk,          // System clock.
  input  logic                  arst_n,       // Asynchronous reset, active low.
  input  cache_pkg::cpu_req_t   req,          // Request from the processor.
  input  logic                  tag_wr,       // Tag write from the fill controller.
  input  cache_pkg::tag_entry_t tag_wr_entry, // Entry that goes with tag_wr.
  input  logic                  fill_busy,    // Fill controller is working on a line.
  output cache_pkg::fill_cmd_t  cmd,          // Miss command to the fill controller.
  output logic [5:0]            rd_index,     // Line to read from the data array.
  output logic [2:0]            rd_offset,    // Word to read from the data array.
  output logic                  rsp_valid,    // Response strobe.
  output logic                  rsp_hit,      // Response came from a hit.
  output logic                  busy          // Requester must hold off while high.
);

  cache_pkg::cache_addr_t req_q;  // Request address held until it is answered.
  logic                   req_v;  // A request was taken in the previous cycle.
  logic [5:0]             tag_mem [64];
  logic [63:0]            valid_q; // One valid bit per line.
  cache_pkg::tag_entry_t  tag_rd;  // Entry of the line the held request maps to.
  logic                   hit;
  logic                   busy_q;   // A miss is outstanding.
  logic                   replay;   // Fill has ended, read the held request again.
  logic                   replay_q; // Data array answers the replay this cycle.

  //////////////////////////////////////////////////////////////////////
  // Request register.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_v <= 1'b0;
    end else begin
      req_v <= req.strobe; // Only a one-cycle flag, the address lives on in req_q.
    end
  end

  // The address is kept after the strobe so that a miss can be replayed.
  always_ff @(posedge clk) begin
    if (req.strobe) begin
      req_q <= req.addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag array. The fill always targets the line of the held request.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tag_wr) begin
      tag_mem[req_q.fields.index] <= tag_wr_entry.tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0; // Every line starts out empty.
    end else if (tag_wr) begin
      valid_q[req_q.fields.index] <= tag_wr_entry.valid;
    end
  end

  assign tag_rd.tag   = tag_mem[req_q.fields.index];
  assign tag_rd.valid = valid_q[req_q.fields.index];

  // An invalid line never hits, whatever its stale tag holds.
  assign hit = req_v & tag_rd.valid & (tag_rd.tag == req_q.fields.tag);

  // A miss asks for the whole block, so the low four bits are cleared.
  assign cmd.miss     = req_v & ~hit;
  assign cmd.addr.raw = {req_q.raw[15:4], 4'h0};

  //////////////////////////////////////////////////////////////////////
  // Miss and replay control.
  //////////////////////////////////////////////////////////////////////
  // The fill controller raises fill_busy on the same edge that sets busy_q,
  // so the first cycle with busy_q high and fill_busy low is the end of the fill.
  assign replay = busy_q & ~fill_busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q   <= 1'b0;
      replay_q <= 1'b0;
    end else begin
      replay_q <= replay; // The registered read is ready one cycle later.
      if (cmd.miss) begin
        busy_q <= 1'b1;
      end else if (replay) begin
        busy_q <= 1'b0; // Drops together with the replay response.
      end
    end
  end

  assign busy = busy_q | cmd.miss; // High already in the cycle the miss is seen.

  // A replay reports hit low, which marks the long latency to the requester.
  assign rsp_valid = hit | replay_q;
  assign rsp_hit   = hit;

  // Hits read with the incoming address. The replay reads the held one.
  assign rd_index  = replay ? req_q.fields.index  : req.addr.fields.index;
  assign rd_offset = replay ? req_q.fields.offset : req.addr.fields.offset;

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cache geometry.
  //////////////////////////////////////////////////////////////////////
  localparam int LINE_WORDS = 8; // Sixteen-bit words held by one cache line.

  // Field view of a byte address, most significant field first.
  typedef struct packed {
    logic [5:0] tag;      // Compared against the stored tag of the line.
    logic [5:0] index;    // Selects one of the 64 lines.
    logic [2:0] offset;   // Word inside the line.
    logic       byte_sel; // Byte inside the word, not used by word fetches.
  } cache_fields_t;

  // The lookup decodes the fields, while the memory side counts on the raw word.
  typedef union packed {
    logic [15:0]   raw;    // Plain 16-bit address.
    cache_fields_t fields; // Same bits split into tag, index, offset and byte.
  } cache_addr_t;

  // One entry of the tag array.
  typedef struct packed {
    logic [5:0] tag;   // Tag of the block that lives in the line.
    logic       valid; // Line holds a complete block.
  } tag_entry_t;

  // Processor request, the strobe is high for a single cycle.
  typedef struct packed {
    logic        strobe; // Request is present this cycle.
    cache_addr_t addr;   // Byte address of the instruction word.
  } cpu_req_t;

  // Cache response, again a single-cycle strobe.
  typedef struct packed {
    logic        strobe; // Response is present this cycle.
    logic        hit;    // Set when the word came straight from the cache.
    logic [15:0] data;   // Instruction word.
  } cpu_rsp_t;

  typedef struct packed {
    logic        miss; // One-cycle strobe that starts a line fill.
    cache_addr_t addr; // Block base address, offset and byte bits are zero.
  } fill_cmd_t;

  typedef struct packed {
    logic        strobe; // Write one word into the data array.
    cache_addr_t addr;   // Address of the word being written.
    logic [15:0] data;   // Word returned by main memory.
  } fill_wr_t;

endpackage
